// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpuTypesPkg.sv
      - rtl/cacheTypesPkg.sv
      - rtl/dcacheArray.sv
      - rtl/dcacheControl.sv
      - rtl/dcacheTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/dcacheAssert.sv
      - test/dcacheTb.sv

// File: rtl/cacheTypesPkg.sv
// ******************************
// Cache side types
// Frame contents, array write commands
// and the memory bus structs
// ******************************
`include "dcacheSettings.svh"

package cacheTypesPkg;

    // One way of one set
    typedef struct packed {
        logic                                          valid;
        logic                                          dirty;
        cpuTypesPkg::tag_t                             tag;
        cpuTypesPkg::word_t [`DCACHE_BLOCK_WORDS-1:0] data;
    } cacheFrame_t;

    // Write command from controller to array
    typedef struct packed {
        logic               en;
        logic               way;
        cpuTypesPkg::idx_t  idx;
        cpuTypesPkg::blk_t  blk;
        cpuTypesPkg::word_t data;
        logic               setTag;
        cpuTypesPkg::tag_t  tag;
        logic               valid;
        logic               dirty;
        logic               writeMeta;
        logic               touch;
    } frameWrite_t;

    typedef struct packed {
        logic               ren;
        logic               wen;
        cpuTypesPkg::word_t addr;
        cpuTypesPkg::word_t store;
    } memReq_t;

    // memWait high holds the current transfer
    typedef struct packed {
        logic               memWait;
        cpuTypesPkg::word_t load;
    } memResp_t;

endpackage

// File: rtl/cpuTypesPkg.sv
// ******************************
// Processor side types
// Data word, address decode and the
// datapath request to the data cache
// ******************************
`include "dcacheSettings.svh"

package cpuTypesPkg;

    typedef logic [31:0] word_t;

    // Address fields follow the cache geometry
    typedef logic [$clog2(`DCACHE_SETS)-1:0] idx_t;
    typedef logic [$clog2(`DCACHE_BLOCK_WORDS)-1:0] blk_t;
    typedef logic [31-$bits(idx_t)-$bits(blk_t)-2:0] tag_t;

    typedef struct packed {
        tag_t       tag;
        idx_t       idx;
        blk_t       blk;
        logic [1:0] bytes;
    } cacheAddrFields_t;

    // Same word seen raw by memory or split by the cache
    typedef union packed {
        word_t            raw;
        cacheAddrFields_t fields;
    } cacheAddr_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        cacheAddr_t addr;
        word_t      store;
    } dcacheReq_t;

endpackage

// File: rtl/dcacheArray.sv
// ******************************
// Data cache storage
// Tags, data, valid, dirty and LRU bits
// for both ways, with the tag compare
// ******************************
`timescale 1ns/1ns
`include "dcacheSettings.svh"

module dcacheArray
(
    input  logic                       CLK,
    input  logic                       reset,
    input  cpuTypesPkg::cacheAddr_t    lookupAddr,
    input  cacheTypesPkg::frameWrite_t wr,
    output cacheTypesPkg::cacheFrame_t frames [`DCACHE_WAYS],
    output logic                       hit,
    output logic                       hitWay,
    output logic                       lruWay
);
    import cpuTypesPkg::*;

    tag_t  tagStore  [`DCACHE_WAYS][`DCACHE_SETS];
    word_t dataStore [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_BLOCK_WORDS];

    logic [`DCACHE_SETS-1:0] validBits [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0] dirtyBits [`DCACHE_WAYS];

    // One bit per set naming the least recently used way
    logic [`DCACHE_SETS-1:0] lruBits;

    // Read out the indexed set and compare tags
    always_comb
    begin
        hit = 1'b0;
        hitWay = 1'b0;
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            frames[w].valid = validBits[w][lookupAddr.fields.idx];
            frames[w].dirty = dirtyBits[w][lookupAddr.fields.idx];
            frames[w].tag = tagStore[w][lookupAddr.fields.idx];
            for (int b = 0; b < `DCACHE_BLOCK_WORDS; b++)
            begin
                frames[w].data[b] = dataStore[w][lookupAddr.fields.idx][b];
            end
            if (frames[w].valid && frames[w].tag == lookupAddr.fields.tag)
            begin
                hit = 1'b1;
                hitWay = w[0];
            end
        end
    end

    assign lruWay = lruBits[lookupAddr.fields.idx];

    // Control bits
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int w = 0; w < `DCACHE_WAYS; w++)
            begin
                validBits[w] <= '0;
                dirtyBits[w] <= '0;
            end
            lruBits <= '0;
        end
        else
        begin
            if (wr.writeMeta)
            begin
                validBits[wr.way][wr.idx] <= wr.valid;
                dirtyBits[wr.way][wr.idx] <= wr.dirty;
            end
            // The other way becomes the victim
            if (wr.touch)
            begin
                lruBits[wr.idx] <= ~wr.way;
            end
        end
    end

    // Tag and data words
    always_ff @(posedge CLK)
    begin
        if (wr.setTag)
        begin
            tagStore[wr.way][wr.idx] <= wr.tag;
        end
        if (wr.en)
        begin
            dataStore[wr.way][wr.idx][wr.blk] <= wr.data;
        end
    end

endmodule

// File: rtl/dcacheControl.sv
// ******************************
// Data cache controller
// Answers hits, runs write-back and fill
// on a miss, and flushes on halt before
// writing out the hit count
// ******************************
`timescale 1ns/1ns
`include "dcacheSettings.svh"

module dcacheControl
(
    input  logic                       CLK,
    input  logic                       reset,
    input  logic                       halt,
    input  cpuTypesPkg::dcacheReq_t    dreq,
    output logic                       dhit,
    output cpuTypesPkg::word_t         dmemload,
    output logic                       flushed,
    output cpuTypesPkg::cacheAddr_t    lookupAddr,
    output cacheTypesPkg::frameWrite_t wr,
    input  cacheTypesPkg::cacheFrame_t frames [`DCACHE_WAYS],
    input  logic                       hit,
    input  logic                       hitWay,
    input  logic                       lruWay,
    output cacheTypesPkg::memReq_t     memReq,
    input  cacheTypesPkg::memResp_t    memResp
);
    import cpuTypesPkg::*;
    import cacheTypesPkg::*;

    typedef enum logic [3:0] {
        Idle, WriteBack0, WriteBack1, Fetch0, Fetch1,
        FlushScan, Flush0, Flush1, HitCountWrite, FlushDone
    } state_t;

    state_t      state;
    state_t      nextState;
    logic        victimWay;
    logic        missPending;
    word_t       hitCount;
    logic        request;
    logic        memDone;
    logic        missStart;
    logic        victimDirty;
    logic        flushing;
    blk_t        blkSel;
    logic        srcWay;
    cacheFrame_t srcFrame;
    cacheAddr_t  memAddr;
    logic        scanStep;

    // Scan pointer is {set, way}, way in the low bit
    logic [$bits(idx_t):0] scanPtr;
    idx_t                  scanIdx;
    logic                  scanWay;
    logic                  scanLast;

    assign request = dreq.ren | dreq.wen;
    assign memDone = ~memResp.memWait;
    assign scanIdx = scanPtr[$bits(idx_t):1];
    assign scanWay = scanPtr[0];
    assign scanLast = &scanPtr;
    assign flushing = state inside {FlushScan, Flush0, Flush1};
    assign blkSel = blk_t'(state inside {WriteBack1, Fetch1, Flush1});

    assign dhit = (state == Idle) && request && hit;
    assign dmemload = frames[hitWay].data[dreq.addr.fields.blk];
    assign flushed = (state == FlushDone);

    assign victimDirty = frames[lruWay].valid && frames[lruWay].dirty;
    assign missStart = (state == Idle) && !halt && request && !hit;

    // Flush looks at its own set, otherwise the request's set
    always_comb
    begin
        lookupAddr = dreq.addr;
        if (flushing)
        begin
            lookupAddr = '0;
            lookupAddr.fields.idx = scanIdx;
        end
    end

    assign srcWay = flushing ? scanWay : victimWay;
    assign srcFrame = frames[srcWay];
    assign scanStep = (state == FlushScan && !(srcFrame.valid && srcFrame.dirty) && !scanLast)
        || (state == Flush1 && memDone && !scanLast);

    always_comb
    begin
        nextState = state;
        case (state)
            Idle:
                if (halt)
                begin
                    nextState = FlushScan;
                end
                else if (missStart)
                begin
                    nextState = victimDirty ? WriteBack0 : Fetch0;
                end
            WriteBack0:
                if (memDone) nextState = WriteBack1;
            WriteBack1:
                if (memDone) nextState = Fetch0;
            Fetch0:
                if (memDone) nextState = Fetch1;
            Fetch1:
                if (memDone) nextState = Idle;
            FlushScan:
                if (srcFrame.valid && srcFrame.dirty)
                begin
                    nextState = Flush0;
                end
                else if (scanLast)
                begin
                    nextState = HitCountWrite;
                end
            Flush0:
                if (memDone) nextState = Flush1;
            Flush1:
                if (memDone) nextState = scanLast ? HitCountWrite : FlushScan;
            HitCountWrite:
                if (memDone) nextState = FlushDone;
            default:
                nextState = state;
        endcase
    end

    // Memory request, held steady by the state while memWait is high
    always_comb
    begin
        memReq = '0;
        memAddr = '0;
        memAddr.fields.idx = lookupAddr.fields.idx;
        memAddr.fields.blk = blkSel;
        case (state)
            WriteBack0, WriteBack1, Flush0, Flush1:
            begin
                memAddr.fields.tag = srcFrame.tag;
                memReq.wen = 1'b1;
                memReq.store = srcFrame.data[blkSel];
            end
            Fetch0, Fetch1:
            begin
                memAddr.fields.tag = dreq.addr.fields.tag;
                memReq.ren = 1'b1;
            end
            HitCountWrite:
            begin
                memAddr.raw = `DCACHE_HITCOUNT_ADDR;
                memReq.wen = 1'b1;
                memReq.store = hitCount;
            end
            default:
                memReq = '0;
        endcase
        memReq.addr = memAddr.raw;
    end

    // Array writes
    always_comb
    begin
        wr = '0;
        wr.way = srcWay;
        wr.idx = lookupAddr.fields.idx;
        wr.blk = blkSel;
        wr.tag = dreq.addr.fields.tag;
        wr.data = memResp.load;
        if (dhit)
        begin
            wr.way = hitWay;
            wr.touch = 1'b1;
            if (dreq.wen)
            begin
                wr.en = 1'b1;
                wr.blk = dreq.addr.fields.blk;
                wr.data = dreq.store;
                wr.writeMeta = 1'b1;
                wr.valid = 1'b1;
                wr.dirty = 1'b1;
            end
        end
        else if ((state == Fetch0 || state == Fetch1) && memDone)
        begin
            wr.en = 1'b1;
            // Second word completes the block
            if (state == Fetch1)
            begin
                wr.setTag = 1'b1;
                wr.writeMeta = 1'b1;
                wr.valid = 1'b1;
            end
        end
        else if (state == Flush1 && memDone)
        begin
            wr.writeMeta = 1'b1;
            wr.valid = 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state <= Idle;
            victimWay <= 1'b0;
            missPending <= 1'b0;
            hitCount <= '0;
            scanPtr <= '0;
        end
        else
        begin
            state <= nextState;
            if (missStart)
            begin
                victimWay <= lruWay;
                missPending <= 1'b1;
            end
            // A hit that ends a miss is not counted
            if (dhit)
            begin
                missPending <= 1'b0;
                if (!missPending)
                begin
                    hitCount <= hitCount + 1'b1;
                end
            end
            if (scanStep)
            begin
                scanPtr <= scanPtr + 1'b1;
            end
        end
    end

endmodule

// File: rtl/dcacheSettings.svh
// ******************************
// Data cache settings
// Geometry of the two-way cache and the
// address that takes the hit count
// ******************************
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Cache geometry
`define DCACHE_WAYS 2
`define DCACHE_SETS 8
`define DCACHE_BLOCK_WORDS 2

// Hit count is written here once the flush is over
`define DCACHE_HITCOUNT_ADDR 32'h0000_3100

`endif

// File: rtl/dcacheTop.sv
// ******************************
// Data cache top level
// Storage array and controller between
// the datapath and main memory
// ******************************
`timescale 1ns/1ns
`include "dcacheSettings.svh"

module dcacheTop
(
    input  logic                    CLK,
    input  logic                    reset,
    input  logic                    halt,
    input  cpuTypesPkg::dcacheReq_t dreq,
    output logic                    dhit,
    output cpuTypesPkg::word_t      dmemload,
    output logic                    flushed,
    output cacheTypesPkg::memReq_t  memReq,
    input  cacheTypesPkg::memResp_t memResp
);
    import cpuTypesPkg::*;
    import cacheTypesPkg::*;

    cacheAddr_t  lookupAddr;
    frameWrite_t wr;
    cacheFrame_t frames [`DCACHE_WAYS];
    logic        hit;
    logic        hitWay;
    logic        lruWay;

    dcacheArray dataArray (
        .CLK, .reset, .lookupAddr, .wr, .frames, .hit, .hitWay, .lruWay
    );

    dcacheControl controller (
        .CLK, .reset, .halt, .dreq, .dhit, .dmemload, .flushed, .lookupAddr, .wr,
        .frames, .hit, .hitWay, .lruWay, .memReq, .memResp
    );

endmodule

// File: sim.f
+incdir+rtl
rtl/cpuTypesPkg.sv
rtl/cacheTypesPkg.sv
rtl/dcacheArray.sv
rtl/dcacheControl.sv
rtl/dcacheTop.sv
test/dcacheAssert.sv
test/dcacheTb.sv

// File: test/dcacheAssert.sv
// ******************************
// Data cache protocol checks
// Memory handshake and flush state,
// bound into the controller
// ******************************
`timescale 1ns/1ns

module dcacheAssert
(
    input logic                    CLK,
    input logic                    reset,
    input cacheTypesPkg::memReq_t  memReq,
    input cacheTypesPkg::memResp_t memResp,
    input logic                    flushed,
    input logic                    dhit
);

    oneOperation: assert property (@(posedge CLK) disable iff (reset)
        !(memReq.ren && memReq.wen))
        else $error("memReq has ren and wen high together");

    // A stalled request must not move
    heldWhileWait: assert property (@(posedge CLK) disable iff (reset)
        (memReq.ren || memReq.wen) && memResp.memWait |=> $stable(memReq))
        else $error("memReq changed while memory wait was high");

    flushedSticky: assert property (@(posedge CLK) disable iff (reset)
        flushed |=> flushed)
        else $error("flushed fell without a reset");

    noHitWhenFlushed: assert property (@(posedge CLK) disable iff (reset)
        !(dhit && flushed))
        else $error("dhit high while flushed");

endmodule

bind dcacheControl dcacheAssert protocolCheck (
    .CLK(CLK), .reset(reset), .memReq(memReq), .memResp(memResp),
    .flushed(flushed), .dhit(dhit)
);

// File: test/dcacheTb.sv
// ******************************
// Data cache testbench
// Memory model with random wait, directed
// tests for hits, misses, LRU, write-back
// and halt flush, then random traffic
// ******************************
`timescale 1ns/1ns
`include "dcacheSettings.svh"

module dcacheTb;
    import cpuTypesPkg::*;
    import cacheTypesPkg::*;

    logic       CLK = 1'b0;
    logic       reset;
    logic       halt;
    dcacheReq_t dreq;
    logic       dhit;
    word_t      dmemload;
    logic       flushed;
    memReq_t    memReq;
    memResp_t   memResp;

    // Memory model and reference memory cover byte addresses below 0x4000
    word_t       memWords [0:4095];
    bit          memWritten [0:4095];
    word_t       refWords [0:4095];
    bit          refWritten [0:4095];
    word_t       wrAddrLog [$];
    word_t       wrDataLog [$];
    word_t       rdAddrLog [$];
    int unsigned waitSeed = 84953;
    int unsigned trafficSeed = 84953;
    int          waitLeft;
    bit          busy;
    int          tbHits;
    int          valueErrors;
    int          timeoutErrors;

    dcacheTop DUT (
        .CLK, .reset, .halt, .dreq, .dhit, .dmemload, .flushed, .memReq, .memResp
    );

    always #5 CLK = ~CLK;

    function automatic int unsigned lcgStep(input int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten memory returns a word built from the whole address
    function automatic word_t fillWord(input word_t addr);
        return ~addr ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic word_t makeAddr(input int tag, input int idx, input int blk);
        return {tag[25:0], idx[2:0], blk[0], 2'b00};
    endfunction

    function automatic word_t memRead(input word_t addr);
        return memWritten[addr[13:2]] ? memWords[addr[13:2]] : fillWord(addr);
    endfunction

    function automatic word_t refRead(input word_t addr);
        return refWritten[addr[13:2]] ? refWords[addr[13:2]] : fillWord(addr);
    endfunction

    // Memory holds wait high for 0 to 3 cycles before each transfer
    always @(negedge CLK)
    begin
        if (reset || !(memReq.ren || memReq.wen))
        begin
            memResp.memWait = 1'b1;
            busy = 1'b0;
        end
        else
        begin
            if (!busy)
            begin
                busy = 1'b1;
                waitSeed = lcgStep(waitSeed);
                waitLeft = (waitSeed >> 16) % 4;
            end
            if (waitLeft > 0)
            begin
                memResp.memWait = 1'b1;
                waitLeft--;
            end
            else
            begin
                // Transfer completes at the next rising edge
                memResp.memWait = 1'b0;
                busy = 1'b0;
                if (memReq.wen)
                begin
                    memWords[memReq.addr[13:2]] = memReq.store;
                    memWritten[memReq.addr[13:2]] = 1'b1;
                    wrAddrLog.push_back(memReq.addr);
                    wrDataLog.push_back(memReq.store);
                end
                else
                begin
                    memResp.load = memRead(memReq.addr);
                    rdAddrLog.push_back(memReq.addr);
                end
            end
        end
    end

    task automatic checkValue(input string testName, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected %h, actual %h", testName, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        halt = 1'b0;
        dreq = '0;
        repeat (10) @(negedge CLK);
        reset = 1'b0;
        tbHits = 0;
        wrAddrLog.delete();
        wrDataLog.delete();
        rdAddrLog.delete();
    endtask

    // One access is held until dhit and starts and ends on a falling edge
    task automatic access(input logic isStore, input word_t addr, input word_t data,
                          output word_t loadVal, output logic firstHit);
        int cycles;
        dreq.ren = !isStore;
        dreq.wen = isStore;
        dreq.addr.raw = addr;
        dreq.store = data;
        firstHit = 1'b0;
        loadVal = '0;
        cycles = 0;
        #1;
        while (!dhit && cycles < 100)
        begin
            @(negedge CLK);
            #1;
            cycles++;
        end
        if (!dhit)
        begin
            $display("Timeout: access to address %h never got dhit", addr);
            timeoutErrors++;
        end
        else
        begin
            firstHit = (cycles == 0);
            loadVal = dmemload;
            if (firstHit)
            begin
                tbHits++;
            end
            if (isStore)
            begin
                refWords[addr[13:2]] = data;
                refWritten[addr[13:2]] = 1'b1;
            end
        end
        @(negedge CLK);
        dreq = '0;
    endtask

    task automatic loadCheck(input string testName, input word_t addr, input logic expectHit);
        word_t value;
        logic  firstHit;
        access(1'b0, addr, '0, value, firstHit);
        checkValue(testName, refRead(addr), value);
        checkValue({testName, " first-cycle hit"}, word_t'(expectHit), word_t'(firstHit));
    endtask

    task automatic storeCheck(input string testName, input word_t addr, input word_t data,
                              input logic expectHit);
        word_t value;
        logic  firstHit;
        access(1'b1, addr, data, value, firstHit);
        checkValue({testName, " first-cycle hit"}, word_t'(expectHit), word_t'(firstHit));
    endtask

    // Halt, wait for flushed, then check the hit count write and the idle cache
    task automatic runHalt(input string testName, input word_t residentAddr);
        int cycles;
        halt = 1'b1;
        cycles = 0;
        while (!flushed && cycles < 500)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (!flushed)
        begin
            $display("Timeout: flushed did not rise after halt in %s", testName);
            timeoutErrors++;
        end
        else
        begin
            checkValue({testName, " write count"}, 1, wrAddrLog.size() > 0);
            if (wrAddrLog.size() > 0)
            begin
                checkValue({testName, " hit count address"}, `DCACHE_HITCOUNT_ADDR,
                    wrAddrLog[$]);
                checkValue({testName, " hit count"}, word_t'(tbHits), wrDataLog[$]);
            end
            // A resident load must get no answer once flushed
            dreq.ren = 1'b1;
            dreq.addr.raw = residentAddr;
            repeat (4)
            begin
                @(negedge CLK);
                #1;
                checkValue({testName, " flushed held"}, 1, flushed);
                checkValue({testName, " dhit after flush"}, 0, dhit);
            end
            @(negedge CLK);
            dreq = '0;
        end
    endtask

    task automatic readMissHit();
        word_t base;
        base = makeAddr(1, 2, 0);
        rdAddrLog.delete();
        loadCheck("readMissHit", base, 1'b0);
        checkValue("readMissHit read count", 2, rdAddrLog.size());
        if (rdAddrLog.size() == 2)
        begin
            checkValue("readMissHit first read", base, rdAddrLog[0]);
            checkValue("readMissHit second read", base + 4, rdAddrLog[1]);
        end
        loadCheck("readMissHit", base + 4, 1'b1);
    endtask

    task automatic lruReplace();
        rdAddrLog.delete();
        loadCheck("lruReplace", makeAddr(10, 5, 0), 1'b0);
        loadCheck("lruReplace", makeAddr(11, 5, 0), 1'b0);
        loadCheck("lruReplace", makeAddr(11, 5, 1), 1'b1);
        // Tag 10 is least recent and goes
        loadCheck("lruReplace", makeAddr(12, 5, 0), 1'b0);
        loadCheck("lruReplace", makeAddr(10, 5, 1), 1'b0);
        loadCheck("lruReplace", makeAddr(12, 5, 1), 1'b1);
        checkValue("lruReplace read count", 8, rdAddrLog.size());
    endtask

    task automatic writeBack();
        word_t base;
        base = makeAddr(20, 3, 0);
        loadCheck("writeBack", base, 1'b0);
        storeCheck("writeBack", base + 4, 32'hDEAD_BEEF, 1'b1);
        loadCheck("writeBack", base + 4, 1'b1);
        wrAddrLog.delete();
        wrDataLog.delete();
        loadCheck("writeBack", makeAddr(21, 3, 0), 1'b0);
        loadCheck("writeBack", makeAddr(22, 3, 0), 1'b0);
        checkValue("writeBack write count", 2, wrAddrLog.size());
        if (wrAddrLog.size() == 2)
        begin
            checkValue("writeBack first address", base, wrAddrLog[0]);
            checkValue("writeBack first data", fillWord(base), wrDataLog[0]);
            checkValue("writeBack second address", base + 4, wrAddrLog[1]);
            checkValue("writeBack second data", 32'hDEAD_BEEF, wrDataLog[1]);
        end
    endtask

    task automatic haltFlush();
        word_t bases [3];
        // Expected flush order is set 1 way 0, set 6 way 0, set 6 way 1
        bases[0] = makeAddr(31, 1, 0);
        bases[1] = makeAddr(30, 6, 0);
        bases[2] = makeAddr(32, 6, 0);
        storeCheck("haltFlush", bases[1], 32'h1111_0000, 1'b0);
        storeCheck("haltFlush", bases[0] + 4, 32'h2222_0001, 1'b0);
        storeCheck("haltFlush", bases[2], 32'h3333_0000, 1'b0);
        wrAddrLog.delete();
        wrDataLog.delete();
        runHalt("haltFlush", bases[2]);
        checkValue("haltFlush write count", 7, wrAddrLog.size());
        if (wrAddrLog.size() == 7)
        begin
            for (int i = 0; i < 6; i++)
            begin
                checkValue("haltFlush address", bases[i / 2] + 4 * (i % 2), wrAddrLog[i]);
                checkValue("haltFlush data", refRead(bases[i / 2] + 4 * (i % 2)), wrDataLog[i]);
            end
        end
    endtask

    task automatic randomTraffic();
        word_t addr;
        word_t data;
        word_t value;
        logic  isStore;
        logic  firstHit;
        // Four tags over two sets keep both ways in conflict
        for (int i = 0; i < 300; i++)
        begin
            trafficSeed = lcgStep(trafficSeed);
            addr = makeAddr(40 + (trafficSeed >> 8) % 4, (trafficSeed >> 12) % 2,
                (trafficSeed >> 16) % 2);
            isStore = ((trafficSeed >> 20) % 3) == 0;
            trafficSeed = lcgStep(trafficSeed);
            data = trafficSeed;
            access(isStore, addr, data, value, firstHit);
            if (!isStore)
            begin
                checkValue("randomTraffic load", refRead(addr), value);
            end
        end
        // The last address accessed is still resident
        runHalt("randomTraffic", addr);
        for (int i = 0; i < 4096; i++)
        begin
            addr = word_t'(i) << 2;
            if (addr != `DCACHE_HITCOUNT_ADDR)
            begin
                checkValue("randomTraffic memory", refRead(addr), memRead(addr));
            end
        end
    endtask

    initial
    begin
        reset = 1'b1;
        halt = 1'b0;
        dreq = '0;
        memResp = '0;
        memResp.memWait = 1'b1;
        busy = 1'b0;
        waitLeft = 0;
        valueErrors = 0;
        timeoutErrors = 0;
        tbHits = 0;
        applyReset();
        readMissHit();
        lruReplace();
        writeBack();
        haltFlush();
        // Memory keeps the flushed data across this reset
        applyReset();
        randomTraffic();
        $display("Errors: %0d value mismatches, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
